//--- logic/mac_pkg.sv
// widths, size encodings and fsm state encoding
// shared by the multiple access controller blocks

`default_nettype none

package mac_pkg;

  // --------------------------------------------------------------------------
  // datapath widths
  // --------------------------------------------------------------------------

  localparam int data_width = 32;  // internal word, also the memory bus
  localparam int lane_count = 4;   // read byte lanes
  localparam int lane_width = 8;   // bits per lane

  // --------------------------------------------------------------------------
  // transfer and bus size, log2 of the byte count
  // --------------------------------------------------------------------------

  typedef enum logic [1:0] {
    size_8    = 2'd0,  // one byte
    size_16   = 2'd1,  // halfword
    size_32   = 2'd2,  // full word
    size_rsvd = 2'd3   // illegal on the request port
  } xfer_size_e;

  // --------------------------------------------------------------------------
  // sequencer fsm
  // --------------------------------------------------------------------------

  typedef enum logic [1:0] {
    st_idle,     // waiting for a request, req_ready high
    st_access,   // mem_req high until mem_ack
    st_gap,      // one dead cycle between beats
    st_respond   // waiting out the response
  } mac_state_e;

  // chunk number in bus-width units, low end is chunk 0
  typedef logic [1:0] chunk_idx_t;

endpackage

`default_nettype wire

//--- logic/access_sequencer.sv
// request acceptance, beat counter and memory strobe
// plus write slice selection for each external beat

`default_nettype none

module access_sequencer
(
  input  logic                                sys_clk1,
  input  logic                                n_sys_reset1,
  // request port
  input  logic                                req_valid,
  input  logic                                req_write,
  input  mac_pkg::xfer_size_e                 req_size,
  input  mac_pkg::xfer_size_e                 bus_size,
  input  logic [mac_pkg::data_width-1:0]      req_wdata,
  output logic                                req_ready,
  // memory port
  output logic                                mem_req,
  output logic                                mem_write,
  output logic [mac_pkg::data_width-1:0]      mem_wdata,
  input  logic                                mem_ack,
  // to lanes and assembler
  output logic                                lane_clear,
  output mac_pkg::chunk_idx_t                 chunk_index,
  output mac_pkg::xfer_size_e                 cur_bus_size,
  output mac_pkg::xfer_size_e                 cur_xfer_size,
  output logic                                last_done
);

  mac_pkg::mac_state_e                state;
  logic                               accept;       // request handshake
  logic                               final_ack;    // ack of the last beat
  logic                               is_write;     // stored req_write
  logic [1:0]                         resp_wait;    // cycles left in st_respond
  logic [mac_pkg::data_width-1:0]     wdata_q;      // masked write data
  logic [mac_pkg::data_width-1:0]     chunk_data;   // selected write slice

  // --------------------------------------------------------------------------
  // size decode
  // --------------------------------------------------------------------------

  // highest chunk index, which is also beats minus one
  function automatic mac_pkg::chunk_idx_t last_chunk
  (
    input mac_pkg::xfer_size_e xs,
    input mac_pkg::xfer_size_e bs
  );
    logic [1:0] diff;
    diff = 2'(xs) - 2'(bs);
    if (xs <= bs)
      last_chunk = 2'd0;       // fits in one beat
    else if (diff == 2'd1)
      last_chunk = 2'd1;       // two beats
    else
      last_chunk = 2'd3;       // word over byte bus
  endfunction

  // keep only the low N bytes of the request word
  function automatic logic [mac_pkg::data_width-1:0] size_mask
  (
    input mac_pkg::xfer_size_e xs
  );
    case (xs)
      mac_pkg::size_8:  size_mask = 32'h0000_00ff;
      mac_pkg::size_16: size_mask = 32'h0000_ffff;
      default:          size_mask = 32'hffff_ffff;
    endcase
  endfunction

  assign req_ready  = (state == mac_pkg::st_idle);
  assign accept     = req_valid & req_ready;
  assign lane_clear = accept;                        // zero lanes at acceptance edge
  assign mem_req    = (state == mac_pkg::st_access);
  assign mem_write  = mem_req & is_write;
  assign final_ack  = mem_req & mem_ack & (chunk_index == 2'd0);

  // --------------------------------------------------------------------------
  // fsm and access counter
  // --------------------------------------------------------------------------

  always_ff @(posedge sys_clk1 or negedge n_sys_reset1)
  begin
    if (!n_sys_reset1)
    begin
      state         <= mac_pkg::st_idle;
      chunk_index   <= 2'd0;
      resp_wait     <= 2'd0;
      is_write      <= 1'b0;
      cur_bus_size  <= mac_pkg::size_8;
      cur_xfer_size <= mac_pkg::size_8;
      last_done     <= 1'b0;
    end
    else
    begin
      last_done <= final_ack;                        // one cycle pulse
      case (state)
        mac_pkg::st_idle:
          if (accept)
          begin
            state         <= mac_pkg::st_access;
            chunk_index   <= last_chunk(req_size, bus_size);  // ms chunk first
            cur_bus_size  <= bus_size;
            cur_xfer_size <= req_size;
            is_write      <= req_write;
          end
        mac_pkg::st_access:
          if (mem_ack)
          begin
            if (chunk_index == 2'd0)
            begin
              state     <= mac_pkg::st_respond;
              resp_wait <= 2'd2;                     // covers assembler stages
            end
            else
            begin
              state       <= mac_pkg::st_gap;
              chunk_index <= chunk_index - 2'd1;     // next lower chunk
            end
          end
        mac_pkg::st_gap:
          state <= mac_pkg::st_access;               // mem_req low one cycle
        mac_pkg::st_respond:
          if (resp_wait == 2'd0)
            state <= mac_pkg::st_idle;               // ready after resp_valid
          else
            resp_wait <= resp_wait - 2'd1;
        default:
          state <= mac_pkg::st_idle;
      endcase
    end
  end

  // write data held for the whole transfer
  always_ff @(posedge sys_clk1)
  begin
    if (accept)
      wdata_q <= req_wdata & size_mask(req_size);
  end

  // --------------------------------------------------------------------------
  // write slice select
  // --------------------------------------------------------------------------

  always_comb
  begin
    chunk_data = '0;
    case (cur_bus_size)
      mac_pkg::size_8:
        chunk_data[7:0] = wdata_q[chunk_index*mac_pkg::lane_width +: 8];
      mac_pkg::size_16:
        chunk_data[15:0] = wdata_q[chunk_index[0]*16 +: 16];
      default:
        chunk_data = wdata_q;                        // whole word in one beat
    endcase
  end

  assign mem_wdata = is_write ? chunk_data : '0;     // reads drive zero

  // --------------------------------------------------------------------------
  // protocol checks
  // --------------------------------------------------------------------------

  // beat held with stable data while memory stalls
  a_req_hold : assert property (@(posedge sys_clk1) disable iff (!n_sys_reset1)
    mem_req && !mem_ack |=> mem_req && $stable(mem_wdata) && $stable(mem_write))
    else $error("mem_req dropped or data changed before mem_ack");

  a_ack_in_req : assert property (@(posedge sys_clk1) disable iff (!n_sys_reset1)
    mem_ack |-> mem_req)
    else $error("mem_ack without mem_req");

  a_legal_size : assert property (@(posedge sys_clk1) disable iff (!n_sys_reset1)
    req_valid |-> (req_size != mac_pkg::size_rsvd) && (bus_size != mac_pkg::size_rsvd))
    else $error("reserved size on request port");

endmodule

`default_nettype wire

//--- logic/byte_lane.sv
// single read byte lane
// picks its byte out of the memory bus when its chunk is acknowledged

`default_nettype none

module byte_lane
#(
  parameter int lane_index = 0       // byte position in the assembled word
)
(
  input  logic                                sys_clk1,
  input  logic                                n_sys_reset1,
  input  logic                                lane_clear,
  input  logic                                mem_ack,
  input  mac_pkg::chunk_idx_t                 chunk_index,
  input  mac_pkg::xfer_size_e                 cur_bus_size,
  input  logic [mac_pkg::data_width-1:0]      mem_rdata,
  output logic [mac_pkg::lane_width-1:0]      lane_byte
);

  logic [1:0] lane_id;     // lane_index as a 2 bit value
  logic       in_chunk;    // this byte is carried by the current beat
  logic [1:0] offset;      // byte position inside the chunk

  assign lane_id = 2'(lane_index);

  always_comb
  begin
    in_chunk = 1'b0;
    offset   = 2'd0;
    case (cur_bus_size)
      mac_pkg::size_8:
        in_chunk = (chunk_index == lane_id);         // one byte per beat
      mac_pkg::size_16:
      begin
        in_chunk = (chunk_index[0] == lane_id[1]);   // halfword chunks
        offset   = {1'b0, lane_id[0]};
      end
      mac_pkg::size_32:
      begin
        in_chunk = 1'b1;                             // single beat
        offset   = lane_id;
      end
      default:
        in_chunk = 1'b0;
    endcase
  end

  always_ff @(posedge sys_clk1 or negedge n_sys_reset1)
  begin
    if (!n_sys_reset1)
      lane_byte <= '0;
    else if (lane_clear)
      lane_byte <= '0;                               // new transfer
    else if (mem_ack && in_chunk)
      lane_byte <= mem_rdata[offset*mac_pkg::lane_width +: mac_pkg::lane_width];
  end

  // clear only happens in idle, ack only during an access
  a_clear_vs_ack : assert property (@(posedge sys_clk1) disable iff (!n_sys_reset1)
    !(lane_clear && mem_ack))
    else $error("lane %0d saw lane_clear together with mem_ack", lane_index);

endmodule

`default_nettype wire

//--- logic/read_assembler.sv
// read result register with byte and halfword replication
// and the one cycle response strobe

`default_nettype none

module read_assembler
(
  input  logic                                sys_clk1,
  input  logic                                n_sys_reset1,
  input  logic [mac_pkg::data_width-1:0]      lane_bytes,     // all four lanes
  input  mac_pkg::xfer_size_e                 cur_xfer_size,
  input  logic                                last_done,
  output logic                                resp_valid,
  output logic [mac_pkg::data_width-1:0]      resp_rdata
);

  localparam int half_width = 2 * mac_pkg::lane_width;

  logic                               last_done_q;    // lanes settled
  logic [mac_pkg::data_width-1:0]     replicated;     // next resp_rdata

  // --------------------------------------------------------------------------
  // replicate low N bytes over the word
  // --------------------------------------------------------------------------

  always_comb
  begin
    case (cur_xfer_size)
      mac_pkg::size_8:
        replicated = {mac_pkg::lane_count{lane_bytes[mac_pkg::lane_width-1:0]}};
      mac_pkg::size_16:
        replicated = {(mac_pkg::lane_count/2){lane_bytes[half_width-1:0]}};
      default:
        replicated = lane_bytes;                     // word, no replication
    endcase
  end

  // --------------------------------------------------------------------------
  // response timing
  // --------------------------------------------------------------------------

  always_ff @(posedge sys_clk1 or negedge n_sys_reset1)
  begin
    if (!n_sys_reset1)
    begin
      last_done_q <= 1'b0;
      resp_valid  <= 1'b0;
    end
    else
    begin
      last_done_q <= last_done;                      // final lane capture done
      resp_valid  <= last_done_q;                    // second edge after final ack
    end
  end

  // result word, written once per transfer
  always_ff @(posedge sys_clk1)
  begin
    if (last_done_q)
      resp_rdata <= replicated;
  end

  // last_done is a single pulse per transfer, so the response is too
  a_resp_pulse : assert property (@(posedge sys_clk1) disable iff (!n_sys_reset1)
    resp_valid |=> !resp_valid)
    else $error("resp_valid high for more than one cycle");

endmodule

`default_nettype wire

//--- logic/mac_top.sv
// multiple access controller top level
// sequencer, four read byte lanes and the read assembler

`default_nettype none

module mac_top
(
  input  logic                                sys_clk1,
  input  logic                                n_sys_reset1,
  // request port
  input  logic                                req_valid,
  input  logic                                req_write,
  input  mac_pkg::xfer_size_e                 req_size,
  input  mac_pkg::xfer_size_e                 bus_size,
  input  logic [mac_pkg::data_width-1:0]      req_wdata,
  output logic                                req_ready,
  // memory port
  output logic                                mem_req,
  output logic                                mem_write,
  output logic [mac_pkg::data_width-1:0]      mem_wdata,
  input  logic                                mem_ack,
  input  logic [mac_pkg::data_width-1:0]      mem_rdata,
  // response port
  output logic                                resp_valid,
  output logic [mac_pkg::data_width-1:0]      resp_rdata
);

  logic                               lane_clear;
  mac_pkg::chunk_idx_t                chunk_index;
  mac_pkg::xfer_size_e                cur_bus_size;
  mac_pkg::xfer_size_e                cur_xfer_size;
  logic                               last_done;
  logic [mac_pkg::data_width-1:0]     lane_bytes;     // lane 0 in the low byte

  access_sequencer u_seq
  (
    .sys_clk1      (sys_clk1),
    .n_sys_reset1  (n_sys_reset1),
    .req_valid     (req_valid),
    .req_write     (req_write),
    .req_size      (req_size),
    .bus_size      (bus_size),
    .req_wdata     (req_wdata),
    .req_ready     (req_ready),
    .mem_req       (mem_req),
    .mem_write     (mem_write),
    .mem_wdata     (mem_wdata),
    .mem_ack       (mem_ack),
    .lane_clear    (lane_clear),
    .chunk_index   (chunk_index),
    .cur_bus_size  (cur_bus_size),
    .cur_xfer_size (cur_xfer_size),
    .last_done     (last_done)
  );

  // one lane per byte of the assembled word
  for (genvar g = 0; g < mac_pkg::lane_count; g++)
  begin : g_lane
    byte_lane #(.lane_index(g)) u_lane
    (
      .sys_clk1     (sys_clk1),
      .n_sys_reset1 (n_sys_reset1),
      .lane_clear   (lane_clear),
      .mem_ack      (mem_ack),
      .chunk_index  (chunk_index),
      .cur_bus_size (cur_bus_size),
      .mem_rdata    (mem_rdata),
      .lane_byte    (lane_bytes[g*mac_pkg::lane_width +: mac_pkg::lane_width])
    );
  end

  read_assembler u_asm
  (
    .sys_clk1      (sys_clk1),
    .n_sys_reset1  (n_sys_reset1),
    .lane_bytes    (lane_bytes),
    .cur_xfer_size (cur_xfer_size),
    .last_done     (last_done),
    .resp_valid    (resp_valid),
    .resp_rdata    (resp_rdata)
  );

endmodule

`default_nettype wire

//--- sim/clock_gen.sv
// testbench clock and reset source
// 4 ns clock, active low reset held for 5 rising edges

`default_nettype none

module clock_gen
(
  output logic sys_clk1,
  output logic n_sys_reset1
);
  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    sys_clk1 = 1'b0;
    forever #2 sys_clk1 = ~sys_clk1;       // 2 ns half period
  end

  initial
  begin
    n_sys_reset1 <= 1'b0;
    repeat (5) @(posedge sys_clk1);
    n_sys_reset1 <= 1'b1;                  // release on the 5th edge
  end

endmodule

`default_nettype wire

//--- sim/mac_tb.sv
// testbench for the multiple access controller
// random requests, stalling memory model, reference model and checks

`default_nettype none

module mac_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_xfers   = 300;
  localparam int cycle_limit = num_xfers * (4 * 6 + 6) + 200;

  logic                sys_clk1;
  logic                n_sys_reset1;
  logic                req_valid;
  logic                req_write;
  mac_pkg::xfer_size_e req_size;
  mac_pkg::xfer_size_e bus_size;
  logic [31:0]         req_wdata;
  logic                req_ready;
  logic                mem_req;
  logic                mem_write;
  logic [31:0]         mem_wdata;
  logic                mem_ack;
  logic [31:0]         mem_rdata;
  logic                resp_valid;
  logic [31:0]         resp_rdata;

  integer      seed;
  int          cycle = 0;          // rising edges since time 0
  int          value_errors = 0;
  int          protocol_errors = 0;
  // model of the transfer in flight
  logic        cur_write;
  logic [31:0] cur_wdata;
  logic [31:0] model_word;         // bytes returned by memory, assembled
  int          xbytes;
  int          bbytes;
  int          exp_beats;
  int          beat;
  int          ack_cycle;          // cycle count just after the latest ack edge

  clock_gen u_clk (.sys_clk1(sys_clk1), .n_sys_reset1(n_sys_reset1));

  mac_top UUT
  (
    .sys_clk1(sys_clk1), .n_sys_reset1(n_sys_reset1),
    .req_valid(req_valid), .req_write(req_write), .req_size(req_size),
    .bus_size(bus_size), .req_wdata(req_wdata), .req_ready(req_ready),
    .mem_req(mem_req), .mem_write(mem_write), .mem_wdata(mem_wdata),
    .mem_ack(mem_ack), .mem_rdata(mem_rdata),
    .resp_valid(resp_valid), .resp_rdata(resp_rdata)
  );

  // --------------------------------------------------------------------------
  // reference model helpers
  // --------------------------------------------------------------------------

  function automatic logic [31:0] byte_mask(input int n);
    byte_mask = (n >= 4) ? 32'hffff_ffff : ((32'd1 << (n * 8)) - 32'd1);
  endfunction

  // chunk c of the low xbytes, taken in bus-width units
  function automatic logic [31:0] expected_chunk(input logic [31:0] d, input int c);
    expected_chunk = ((d & byte_mask(xbytes)) >> (c * bbytes * 8)) & byte_mask(bbytes);
  endfunction

  function automatic logic [31:0] replicate_low(input logic [31:0] w, input int n);
    if (n == 1)
      replicate_low = {4{w[7:0]}};
    else if (n == 2)
      replicate_low = {2{w[15:0]}};         // halfword twice
    else
      replicate_low = w;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
    value_errors++;
  endtask

  task automatic report_problem(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    protocol_errors++;
  endtask

  // --------------------------------------------------------------------------
  // memory model, one beat with a random stall
  // --------------------------------------------------------------------------

  task automatic serve_beat();
    int          delay;
    int          chunk;
    logic [31:0] held;
    logic [31:0] rdata;
    logic [31:0] want;
    delay = $unsigned($random(seed)) % 4;
    rdata = $random(seed);
    chunk = exp_beats - 1 - beat;          // ms chunk first
    held  = mem_wdata;
    repeat (delay)
    begin
      @(posedge sys_clk1);
      @(negedge sys_clk1);
      assert (mem_req) else report_problem("mem_req dropped while memory stalled");
      assert (mem_wdata == held) else report_mismatch("mem_wdata", mem_wdata, held);
    end
    @(posedge sys_clk1);
    mem_ack   <= 1'b1;
    mem_rdata <= rdata;
    @(negedge sys_clk1);
    want = (cur_write && chunk >= 0) ? expected_chunk(cur_wdata, chunk) : 32'd0;
    assert (mem_req) else report_problem("mem_ack given while mem_req low");
    assert (mem_write == cur_write) else
      report_mismatch("mem_write", 32'(mem_write), 32'(cur_write));
    assert (mem_wdata == want) else report_mismatch("mem_wdata", mem_wdata, want);
    if (chunk >= 0)
      model_word = model_word | ((rdata & byte_mask(bbytes)) << (chunk * bbytes * 8));
    @(posedge sys_clk1);                   // ack edge
    mem_ack <= 1'b0;
    @(negedge sys_clk1);
    ack_cycle = cycle;
  endtask

  // --------------------------------------------------------------------------
  // one request through to its response
  // --------------------------------------------------------------------------

  task automatic run_transfer();
    int          xs;
    int          bs;
    logic        done;
    logic [31:0] want;
    xs        = $unsigned($random(seed)) % 3;
    bs        = $unsigned($random(seed)) % 3;
    cur_write = ($random(seed) & 1) != 0;
    cur_wdata = $random(seed);
    xbytes    = 1 << xs;
    bbytes    = 1 << bs;
    exp_beats = (xbytes > bbytes) ? xbytes / bbytes : 1;
    beat      = 0;
    model_word = 32'd0;
    done      = 1'b0;
    @(posedge sys_clk1);
    req_valid <= 1'b1;
    req_write <= cur_write;
    req_size  <= mac_pkg::xfer_size_e'(2'(xs));
    bus_size  <= mac_pkg::xfer_size_e'(2'(bs));
    req_wdata <= cur_wdata;
    @(negedge sys_clk1);
    while (!req_ready)
    begin
      @(negedge sys_clk1);
    end
    @(posedge sys_clk1);                   // acceptance edge
    req_valid <= 1'b0;
    while (!done)
    begin
      @(negedge sys_clk1);
      if (resp_valid)
        done = 1'b1;
      else
      begin
        assert (!req_ready) else report_problem("req_ready high during a transfer");
        if (mem_req)
        begin
          serve_beat();
          beat++;
        end
      end
    end
    assert (!req_ready) else report_problem("req_ready high together with resp_valid");
    assert (beat == exp_beats) else report_mismatch("beat count", 32'(beat), 32'(exp_beats));
    assert (cycle == ack_cycle + 2) else
      report_problem("resp_valid not two edges after the final mem_ack");
    if (!cur_write)
    begin
      want = replicate_low(model_word & byte_mask(xbytes), xbytes);
      assert (resp_rdata == want) else report_mismatch("resp_rdata", resp_rdata, want);
    end
    @(negedge sys_clk1);
    assert (!resp_valid) else report_problem("resp_valid high for more than one cycle");
    assert (req_ready) else report_problem("req_ready not back after resp_valid");
  endtask

  // --------------------------------------------------------------------------
  // main sequence and cycle limit
  // --------------------------------------------------------------------------

  initial
  begin
    seed = 32'hda1c;
    req_valid <= 1'b0;
    req_write <= 1'b0;
    req_size  <= mac_pkg::size_8;
    bus_size  <= mac_pkg::size_8;
    req_wdata <= 32'd0;
    mem_ack   <= 1'b0;
    mem_rdata <= 32'd0;
    @(negedge sys_clk1);
    while (!n_sys_reset1)
    begin
      assert (req_ready && !mem_req && !resp_valid) else
        report_problem("outputs not idle during reset");
      @(negedge sys_clk1);
    end
    for (int i = 0; i < num_xfers; i++)
      run_transfer();
    $display("summary: %0d value mismatches, %0d protocol faults in %0d transfers",
             value_errors, protocol_errors, num_xfers);
    if (value_errors + protocol_errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  always @(posedge sys_clk1)
  begin
    cycle <= cycle + 1;
    if (cycle >= cycle_limit)
    begin
      $display("timeout: run passed %0d cycles without finishing", cycle_limit);
      $display("Errors found");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- files.f
logic/mac_pkg.sv
logic/access_sequencer.sv
logic/byte_lane.sv
logic/read_assembler.sv
logic/mac_top.sv
sim/clock_gen.sv
sim/mac_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module mac_tb -f files.f --Mdir obj_dir -o mac_sim > build.log 2>&1 \
  && ./obj_dir/mac_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2> /dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "Errors found" sim.log \
  && { echo "simulation FAILED"; exit 1; } \
  || { echo "simulation passed"; exit 0; }
